// ==== verilog.f ====
cmd_pkg.sv
cmd_parser.sv
pwm_bank.sv
cmd_exec.sv
upload_framer.sv
cdc_core.sv
cdc_core_checker.sv
tb_cdc_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cdc_core
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_cdc_core.sv ====
`timescale 1ns/1ps

module tb_cdc_core;

    localparam int NUM_CH     = 8;
    localparam int PWM_WIDTH  = 8;
    localparam int NUM_FRAMES = 400;
    localparam int MAX_GAP    = 3;
    localparam int MAX_NOISE  = 3;

    // longest frame plus noise, every strobe with a full gap, then the response
    localparam int FRAME_CYCLES   = (5 + MAX_NOISE) * (MAX_GAP + 1) + 12;
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES + NUM_CH) * FRAME_CYCLES + 2 ** PWM_WIDTH + 100;

    logic              clk = 1'b0;
    logic              rst_i;
    cmd_pkg::byte_t    usb_data_i;
    logic              usb_data_valid_i;
    cmd_pkg::byte_t    usb_upload_data_o;
    logic              usb_upload_valid_o;
    logic [NUM_CH-1:0] pwm_o;

    // reference model state
    cmd_pkg::byte_t duty_m [NUM_CH];
    logic [23:0]    exp_q [$];
    int             cyc_q [$];
    int             cycle_cnt   = 0;
    int             last_strobe = 0;

    // response monitor state
    int             rsp_idx = 0;
    logic [23:0]    cur_rsp;
    cmd_pkg::byte_t exp_byte;

    always #10 clk = ~clk;

    cdc_core #(
        .NUM_CH    (NUM_CH),
        .PWM_WIDTH (PWM_WIDTH)
    ) cdc_core_inst (
        .clk                (clk),
        .rst_i              (rst_i),
        .usb_data_i         (usb_data_i),
        .usb_data_valid_i   (usb_data_valid_i),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o),
        .pwm_o              (pwm_o)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            fail_now($sformatf("Mismatch at %0t: %s expected 0x%0h got 0x%0h",
                               $time, name, exp, got));
        end
    endtask

    // ============================================================
    // host side stimulus
    // ============================================================

    task automatic send_byte(input cmd_pkg::byte_t b);
        repeat ($urandom_range(MAX_GAP, 0)) @(negedge clk);
        usb_data_i       = b;
        usb_data_valid_i = 1'b1;
        last_strobe      = cycle_cnt;
        @(negedge clk);
        usb_data_valid_i = 1'b0;
    endtask

    task automatic send_noise();
        cmd_pkg::byte_t b;
        repeat ($urandom_range(MAX_NOISE, 0)) begin
            b = 8'($urandom);
            // a header here would open a frame
            if (b == cmd_pkg::CMD_HEADER) begin
                b = 8'h00;
            end
            send_byte(b);
        end
    endtask

    // kind 0 set, 1 get, 2 ping, 3 set with bad checksum, 4 bad length, else unknown
    task automatic send_frame(input int kind, input int chan);
        cmd_pkg::cmd_t    code;
        cmd_pkg::byte_t   len;
        cmd_pkg::byte_t   p0;
        cmd_pkg::byte_t   p1;
        cmd_pkg::byte_t   chk;
        cmd_pkg::status_t st;
        cmd_pkg::byte_t   data;
        p0   = 8'(chan);
        p1   = 8'($urandom);
        st   = cmd_pkg::ST_OK;
        data = 8'h00;
        case (kind)
            0, 3: begin
                code = cmd_pkg::CMD_SET_DUTY;
                len  = 8'd2;
            end
            1: begin
                code = cmd_pkg::CMD_GET_DUTY;
                len  = 8'd1;
            end
            2: begin
                code = cmd_pkg::CMD_PING;
                len  = 8'($urandom_range(2, 0));
            end
            4: begin
                code = 8'($urandom);
                len  = 8'($urandom_range(255, 3));
            end
            default: begin
                code = 8'($urandom_range(255, 4));
                len  = 8'($urandom_range(2, 0));
            end
        endcase
        send_byte(cmd_pkg::CMD_HEADER);
        send_byte(code);
        send_byte(len);
        if (kind == 4) begin
            // frame ends at the length byte
            st = cmd_pkg::ST_BAD_LENGTH;
        end else begin
            chk = code ^ len;
            if (len > 8'd0) begin
                send_byte(p0);
                chk = chk ^ p0;
            end
            if (len > 8'd1) begin
                send_byte(p1);
                chk = chk ^ p1;
            end
            if (kind == 3) begin
                chk = chk ^ (8'd1 << $urandom_range(7, 0));
            end
            send_byte(chk);
            if (kind == 3) begin
                st = cmd_pkg::ST_BAD_CHECKSUM;
            end else if (code == cmd_pkg::CMD_SET_DUTY || code == cmd_pkg::CMD_GET_DUTY) begin
                if (chan >= NUM_CH) begin
                    st = cmd_pkg::ST_BAD_CHANNEL;
                end else if (code == cmd_pkg::CMD_SET_DUTY) begin
                    duty_m[chan] = p1;
                    data         = p1;
                end else begin
                    data = duty_m[chan];
                end
            end else if (code == cmd_pkg::CMD_PING) begin
                data = cmd_pkg::VERSION_BYTE;
            end else begin
                st = cmd_pkg::ST_BAD_CMD;
            end
        end
        exp_q.push_back({code, st, data});
        cyc_q.push_back(last_strobe + 3);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || usb_upload_valid_o) begin
            @(negedge clk);
        end
    endtask

    // ============================================================
    // response monitor and cycle limit
    // ============================================================

    always @(negedge clk) begin
        if (!rst_i && usb_upload_valid_o) begin
            if (rsp_idx == 0) begin
                assert (exp_q.size() != 0) else begin
                    fail_now("a response frame appeared with no command pending");
                end
                cur_rsp = exp_q.pop_front();
                check_value("usb_upload_valid_o rise cycle", cycle_cnt, cyc_q.pop_front());
            end
            case (rsp_idx)
                0:       exp_byte = cmd_pkg::RSP_HEADER;
                1:       exp_byte = cur_rsp[23:16];
                2:       exp_byte = cur_rsp[15:8];
                3:       exp_byte = cur_rsp[7:0];
                default: exp_byte = cur_rsp[23:16] ^ cur_rsp[15:8] ^ cur_rsp[7:0];
            endcase
            check_value($sformatf("usb_upload_data_o byte %0d", rsp_idx),
                        int'(usb_upload_data_o), int'(exp_byte));
            rsp_idx = (rsp_idx == 4) ? 0 : rsp_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES) else begin
            fail_now("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        int kind;
        int high_cnt [NUM_CH];
        int chk_fails;
        void'($urandom(32'h54cfc26a));
        rst_i            = 1'b1;
        usb_data_i       = '0;
        usb_data_valid_i = 1'b0;
        foreach (duty_m[i]) begin
            duty_m[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_i = 1'b0;

        repeat (NUM_FRAMES) begin
            kind = int'($urandom_range(5, 0));
            send_frame(kind, int'($urandom_range(NUM_CH + 1, 0)));
            wait_idle();
            send_noise();
        end

        // last duty on every channel, then one full pwm period
        for (int ch = 0; ch < NUM_CH; ch++) begin
            send_frame(0, ch);
            wait_idle();
        end
        foreach (high_cnt[ch]) begin
            high_cnt[ch] = 0;
        end
        repeat (2 ** PWM_WIDTH) begin
            @(negedge clk);
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (pwm_o[ch]) begin
                    high_cnt[ch]++;
                end
            end
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            check_value($sformatf("pwm_o[%0d] high cycles", ch), high_cnt[ch], int'(duty_m[ch]));
        end

        chk_fails = cdc_core_inst.cdc_core_checker_inst.burst_long_fails +
                    cdc_core_inst.cdc_core_checker_inst.burst_short_fails +
                    cdc_core_inst.cdc_core_checker_inst.hdr_fails +
                    cdc_core_inst.cdc_core_checker_inst.pwm_fails;
        if (chk_fails == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_now("the bound protocol checker reported assertion failures");
        end
    end

endmodule

// ==== cdc_core_checker.sv ====
`timescale 1ns/1ps

module cdc_core_checker #(
    parameter int NUM_CH = 8
) (
    input  logic              clk,
    input  logic              rst_i,
    input  cmd_pkg::byte_t    upload_data_i,
    input  logic              upload_valid_i,
    input  logic [NUM_CH-1:0] pwm_i
);

    // cycles the upload strobe has been high in a row
    logic [3:0] run_q;

    int burst_long_fails  = 0;
    int burst_short_fails = 0;
    int hdr_fails         = 0;
    int pwm_fails         = 0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            run_q <= '0;
        end else if (upload_valid_i) begin
            run_q <= run_q + 4'd1;
        end else begin
            run_q <= '0;
        end
    end

    // ============================================================
    // response framing
    // ============================================================

    a_burst_long: assert property (@(posedge clk) disable iff (rst_i)
        upload_valid_i |-> run_q < 4'd5)
        else begin
            burst_long_fails++;
            $error("upload strobe high for more than five cycles");
        end

    // a burst that ends must have been exactly five bytes
    a_burst_short: assert property (@(posedge clk) disable iff (rst_i)
        (!upload_valid_i && run_q != 4'd0) |-> run_q == 4'd5)
        else begin
            burst_short_fails++;
            $error("upload strobe dropped before five cycles");
        end

    a_header: assert property (@(posedge clk) disable iff (rst_i)
        (upload_valid_i && run_q == 4'd0) |-> upload_data_i == cmd_pkg::RSP_HEADER)
        else begin
            hdr_fails++;
            $error("first upload byte is not the response header");
        end

    a_pwm_reset: assert property (@(posedge clk) $past(rst_i) |-> pwm_i == '0)
        else begin
            pwm_fails++;
            $error("pwm pins not low right after reset");
        end

endmodule

bind cdc_core cdc_core_checker #(
    .NUM_CH (NUM_CH)
) cdc_core_checker_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .upload_data_i  (usb_upload_data_o),
    .upload_valid_i (usb_upload_valid_o),
    .pwm_i          (pwm_o)
);

// ==== cdc_core.sv ====
`timescale 1ns/1ps

module cdc_core #(
    parameter int NUM_CH    = 8,
    parameter int PWM_WIDTH = 8
) (
    input  logic              clk,
    input  logic              rst_i,
    input  cmd_pkg::byte_t    usb_data_i,
    input  logic              usb_data_valid_i,
    output cmd_pkg::byte_t    usb_upload_data_o,
    output logic              usb_upload_valid_o,
    output logic [NUM_CH-1:0] pwm_o
);

    // ============================================================
    // decode to execute
    // ============================================================

    logic             cmd_valid;
    cmd_pkg::cmd_t    cmd_code;
    cmd_pkg::byte_t   cmd_arg0;
    cmd_pkg::byte_t   cmd_arg1;
    cmd_pkg::byte_t   cmd_len;
    cmd_pkg::status_t cmd_error;

    // execute to upload
    logic             rsp_valid;
    cmd_pkg::cmd_t    rsp_cmd;
    cmd_pkg::status_t rsp_status;
    cmd_pkg::byte_t   rsp_data;

    cmd_parser cmd_parser_inst (
        .clk              (clk),
        .rst_i            (rst_i),
        .usb_data_i       (usb_data_i),
        .usb_data_valid_i (usb_data_valid_i),
        .cmd_valid_o      (cmd_valid),
        .cmd_code_o       (cmd_code),
        .cmd_arg0_o       (cmd_arg0),
        .cmd_arg1_o       (cmd_arg1),
        .cmd_len_o        (cmd_len),
        .cmd_error_o      (cmd_error)
    );

    cmd_exec #(
        .NUM_CH    (NUM_CH),
        .PWM_WIDTH (PWM_WIDTH)
    ) cmd_exec_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid),
        .cmd_code_i   (cmd_code),
        .cmd_arg0_i   (cmd_arg0),
        .cmd_arg1_i   (cmd_arg1),
        .cmd_len_i    (cmd_len),
        .cmd_error_i  (cmd_error),
        .rsp_valid_o  (rsp_valid),
        .rsp_cmd_o    (rsp_cmd),
        .rsp_status_o (rsp_status),
        .rsp_data_o   (rsp_data),
        .pwm_o        (pwm_o)
    );

    upload_framer upload_framer_inst (
        .clk                (clk),
        .rst_i              (rst_i),
        .rsp_valid_i        (rsp_valid),
        .rsp_cmd_i          (rsp_cmd),
        .rsp_status_i       (rsp_status),
        .rsp_data_i         (rsp_data),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o)
    );

endmodule

// ==== upload_framer.sv ====
`timescale 1ns/1ps

module upload_framer (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             rsp_valid_i,
    input  cmd_pkg::cmd_t    rsp_cmd_i,
    input  cmd_pkg::status_t rsp_status_i,
    input  cmd_pkg::byte_t   rsp_data_i,
    output cmd_pkg::byte_t   usb_upload_data_o,
    output logic             usb_upload_valid_o
);

    // response frame is header, cmd, status, data, checksum
    localparam logic [2:0] LAST_IDX = 3'd5;

    cmd_pkg::cmd_t    cmd_q;
    cmd_pkg::status_t status_q;
    cmd_pkg::byte_t   data_q;
    cmd_pkg::byte_t   chk_q;

    // index of the byte to drive on the next cycle
    logic [2:0] idx_q;

    cmd_pkg::byte_t next_byte;

    // ============================================================
    // result latch
    // ============================================================

    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            cmd_q    <= rsp_cmd_i;
            status_q <= rsp_status_i;
            data_q   <= rsp_data_i;
            chk_q    <= rsp_cmd_i ^ rsp_status_i ^ rsp_data_i;
        end
    end

    always_comb begin
        case (idx_q)
            3'd1:    next_byte = cmd_q;
            3'd2:    next_byte = status_q;
            3'd3:    next_byte = data_q;
            3'd4:    next_byte = chk_q;
            default: next_byte = cmd_pkg::RSP_HEADER;
        endcase
    end

    // ============================================================
    // byte walk
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            usb_upload_valid_o <= 1'b0;
            idx_q              <= '0;
        end else if (rsp_valid_i) begin
            // header goes out right away
            usb_upload_valid_o <= 1'b1;
            idx_q              <= 3'd1;
        end else if (usb_upload_valid_o) begin
            if (idx_q == LAST_IDX) begin
                usb_upload_valid_o <= 1'b0;
                idx_q              <= '0;
            end else begin
                idx_q <= idx_q + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            usb_upload_data_o <= cmd_pkg::RSP_HEADER;
        end else if (usb_upload_valid_o && idx_q != LAST_IDX) begin
            usb_upload_data_o <= next_byte;
        end
    end

endmodule

// ==== cmd_exec.sv ====
`timescale 1ns/1ps

module cmd_exec #(
    parameter int NUM_CH    = 8,
    parameter int PWM_WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             cmd_valid_i,
    input  cmd_pkg::cmd_t    cmd_code_i,
    input  cmd_pkg::byte_t   cmd_arg0_i,
    input  cmd_pkg::byte_t   cmd_arg1_i,
    input  cmd_pkg::byte_t   cmd_len_i,
    input  cmd_pkg::status_t cmd_error_i,
    output logic             rsp_valid_o,
    output cmd_pkg::cmd_t    rsp_cmd_o,
    output cmd_pkg::status_t rsp_status_o,
    output cmd_pkg::byte_t   rsp_data_o,
    output logic [NUM_CH-1:0] pwm_o
);

    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    // one duty per channel, packed for the pwm bank
    logic [NUM_CH-1:0][PWM_WIDTH-1:0] duty_q;

    cmd_pkg::byte_t       chan_arg;
    cmd_pkg::byte_t       duty_arg;
    logic                 chan_ok;
    logic [CH_W-1:0]      chan_idx;
    logic [PWM_WIDTH-1:0] duty_new;
    logic                 duty_we;
    cmd_pkg::status_t     status_d;
    cmd_pkg::byte_t       data_d;

    // payload bytes past the frame length count as zero
    assign chan_arg = (cmd_len_i != 8'd0) ? cmd_arg0_i : '0;
    assign duty_arg = (cmd_len_i > 8'd1) ? cmd_arg1_i : '0;

    assign chan_ok  = int'(chan_arg) < NUM_CH;
    assign chan_idx = chan_arg[CH_W-1:0];
    assign duty_new = PWM_WIDTH'(duty_arg);

    // ============================================================
    // status priority and result data
    // ============================================================

    always_comb begin
        status_d = cmd_pkg::ST_OK;
        data_d   = '0;
        if (cmd_error_i != cmd_pkg::ST_OK) begin
            // parser verdict wins over everything
            status_d = cmd_error_i;
        end else begin
            case (cmd_code_i)
                cmd_pkg::CMD_SET_DUTY: begin
                    if (!chan_ok) begin
                        status_d = cmd_pkg::ST_BAD_CHANNEL;
                    end else begin
                        data_d = cmd_pkg::byte_t'(duty_new);
                    end
                end
                cmd_pkg::CMD_GET_DUTY: begin
                    if (!chan_ok) begin
                        status_d = cmd_pkg::ST_BAD_CHANNEL;
                    end else begin
                        data_d = cmd_pkg::byte_t'(duty_q[chan_idx]);
                    end
                end
                cmd_pkg::CMD_PING: begin
                    data_d = cmd_pkg::VERSION_BYTE;
                end
                default: begin
                    status_d = cmd_pkg::ST_BAD_CMD;
                end
            endcase
        end
    end

    assign duty_we = cmd_valid_i && (status_d == cmd_pkg::ST_OK) &&
                     (cmd_code_i == cmd_pkg::CMD_SET_DUTY);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            duty_q      <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= cmd_valid_i;
            if (duty_we) begin
                duty_q[chan_idx] <= duty_new;
            end
        end
    end

    // result fields held until the framer latches them
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            rsp_cmd_o    <= cmd_code_i;
            rsp_status_o <= status_d;
            rsp_data_o   <= data_d;
        end
    end

    pwm_bank #(
        .NUM_CH    (NUM_CH),
        .PWM_WIDTH (PWM_WIDTH)
    ) pwm_bank_inst (
        .clk    (clk),
        .rst_i  (rst_i),
        .duty_i (duty_q),
        .pwm_o  (pwm_o)
    );

endmodule

// ==== pwm_bank.sv ====
`timescale 1ns/1ps

module pwm_bank #(
    parameter int NUM_CH    = 8,
    parameter int PWM_WIDTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [NUM_CH*PWM_WIDTH-1:0] duty_i,
    output logic [NUM_CH-1:0]           pwm_o
);

    // ============================================================
    // shared period counter
    // ============================================================

    // one full sweep of the counter is one pwm period
    logic [PWM_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // ============================================================
    // per-channel compare
    // ============================================================

    logic [NUM_CH-1:0] cmp;

    for (genvar i = 0; i < NUM_CH; i++) begin : g_cmp
        logic [PWM_WIDTH-1:0] duty;

        assign duty   = duty_i[i*PWM_WIDTH +: PWM_WIDTH];

        // high while the count is still below the duty
        assign cmp[i] = cnt_q < duty;
    end

    // registered so the pins see no compare glitches
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pwm_o <= '0;
        end else begin
            pwm_o <= cmp;
        end
    end

endmodule

// ==== cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
    input  logic             clk,
    input  logic             rst_i,
    input  cmd_pkg::byte_t   usb_data_i,
    input  logic             usb_data_valid_i,
    output logic             cmd_valid_o,
    output cmd_pkg::cmd_t    cmd_code_o,
    output cmd_pkg::byte_t   cmd_arg0_o,
    output cmd_pkg::byte_t   cmd_arg1_o,
    output cmd_pkg::byte_t   cmd_len_o,
    output cmd_pkg::status_t cmd_error_o
);

    cmd_pkg::parser_state_t state_q;

    // running xor over command, length and payload
    cmd_pkg::byte_t xor_q;

    // payload bytes taken so far in this frame
    logic [1:0] pay_cnt_q;

    logic len_bad;
    logic pay_last;
    logic chk_ok;

    // length byte larger than a frame may carry
    assign len_bad  = usb_data_i > cmd_pkg::MAX_PAYLOAD;

    // length is never above MAX_PAYLOAD here so two bits suffice
    assign pay_last = (pay_cnt_q + 2'd1) == cmd_len_o[1:0];

    assign chk_ok   = usb_data_i == xor_q;

    // ============================================================
    // frame state machine, advances on strobes only
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= cmd_pkg::PS_HUNT;
            pay_cnt_q   <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (usb_data_valid_i) begin
                case (state_q)
                    cmd_pkg::PS_HUNT: begin
                        // anything but a header is dropped
                        if (usb_data_i == cmd_pkg::CMD_HEADER) begin
                            state_q <= cmd_pkg::PS_COMMAND;
                        end
                    end
                    cmd_pkg::PS_COMMAND: begin
                        state_q <= cmd_pkg::PS_LENGTH;
                    end
                    cmd_pkg::PS_LENGTH: begin
                        pay_cnt_q <= '0;
                        if (len_bad) begin
                            // report at once and give up on the frame
                            cmd_valid_o <= 1'b1;
                            state_q     <= cmd_pkg::PS_HUNT;
                        end else if (usb_data_i == '0) begin
                            state_q <= cmd_pkg::PS_CHECKSUM;
                        end else begin
                            state_q <= cmd_pkg::PS_PAYLOAD;
                        end
                    end
                    cmd_pkg::PS_PAYLOAD: begin
                        pay_cnt_q <= pay_cnt_q + 2'd1;
                        if (pay_last) begin
                            state_q <= cmd_pkg::PS_CHECKSUM;
                        end
                    end
                    cmd_pkg::PS_CHECKSUM: begin
                        cmd_valid_o <= 1'b1;
                        state_q     <= cmd_pkg::PS_HUNT;
                    end
                    default: begin
                        state_q <= cmd_pkg::PS_HUNT;
                    end
                endcase
            end
        end
    end

    // ============================================================
    // command fields and checksum
    // ============================================================

    always_ff @(posedge clk) begin
        if (usb_data_valid_i) begin
            case (state_q)
                cmd_pkg::PS_COMMAND: begin
                    cmd_code_o <= usb_data_i;
                    xor_q      <= usb_data_i;
                end
                cmd_pkg::PS_LENGTH: begin
                    cmd_len_o  <= usb_data_i;
                    // absent payload reads as zero
                    cmd_arg0_o <= '0;
                    cmd_arg1_o <= '0;
                    xor_q      <= xor_q ^ usb_data_i;
                    if (len_bad) begin
                        cmd_error_o <= cmd_pkg::ST_BAD_LENGTH;
                    end
                end
                cmd_pkg::PS_PAYLOAD: begin
                    if (pay_cnt_q == 2'd0) begin
                        cmd_arg0_o <= usb_data_i;
                    end else begin
                        cmd_arg1_o <= usb_data_i;
                    end
                    xor_q <= xor_q ^ usb_data_i;
                end
                cmd_pkg::PS_CHECKSUM: begin
                    cmd_error_o <= chk_ok ? cmd_pkg::ST_OK : cmd_pkg::ST_BAD_CHECKSUM;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== cmd_pkg.sv ====
package cmd_pkg;

    // ============================================================
    // stream types
    // ============================================================

    typedef logic [7:0] byte_t;
    typedef logic [7:0] cmd_t;
    typedef logic [7:0] status_t;

    // ============================================================
    // frame markers and limits
    // ============================================================

    localparam byte_t CMD_HEADER   = 8'hAA;
    localparam byte_t RSP_HEADER   = 8'h55;

    // most payload bytes one host frame may carry
    localparam byte_t MAX_PAYLOAD  = 8'd2;

    // answer to a ping
    localparam byte_t VERSION_BYTE = 8'h21;

    // command codes
    localparam cmd_t CMD_SET_DUTY = 8'h01;
    localparam cmd_t CMD_GET_DUTY = 8'h02;
    localparam cmd_t CMD_PING     = 8'h03;

    // status codes returned in every response
    localparam status_t ST_OK           = 8'h00;
    localparam status_t ST_BAD_CHECKSUM = 8'h01;
    localparam status_t ST_BAD_LENGTH   = 8'h02;
    localparam status_t ST_BAD_CMD      = 8'h03;
    localparam status_t ST_BAD_CHANNEL  = 8'h04;

    // host frame decoder states
    typedef enum logic [2:0] {
        PS_HUNT,
        PS_COMMAND,
        PS_LENGTH,
        PS_PAYLOAD,
        PS_CHECKSUM
    } parser_state_t;

endpackage
